/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    localparam data_t ZERO_WORD = '0;
    localparam addr_t ZERO_ADDR = '0;
    localparam addr_t PC_STEP   = 32'd4;  // Size of one instruction in bytes

    typedef enum logic [5:0] {
        OPENUM_NOP = 6'd0,  // No instruction
        OPENUM_LUI,
        OPENUM_AUIPC,
        OPENUM_JAL,
        OPENUM_JALR,
        OPENUM_BEQ,  // Branches stay consecutive from BEQ to BGEU
        OPENUM_BNE,
        OPENUM_BLT,
        OPENUM_BGE,
        OPENUM_BLTU,
        OPENUM_BGEU,
        OPENUM_ADD,
        OPENUM_SUB,
        OPENUM_SLL,
        OPENUM_SLT,
        OPENUM_SLTU,
        OPENUM_XOR,
        OPENUM_SRL,
        OPENUM_SRA,
        OPENUM_OR,
        OPENUM_AND,
        OPENUM_ADDI,
        OPENUM_SLLI,
        OPENUM_SLTI,
        OPENUM_SLTIU,
        OPENUM_XORI,
        OPENUM_SRLI,
        OPENUM_SRAI,
        OPENUM_ORI,
        OPENUM_ANDI
    } openum_t;

endpackage

/* rtl/rs_pkg.sv */
package rs_pkg;

    import rv_isa_pkg::*;

    localparam int RS_DEPTH = 8;
    localparam int TAG_W    = 4;   // Reorder buffer index width
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    // One station slot, operands hold either a value or the tag of their producer
    typedef struct packed {
        logic    busy;
        openum_t openum;
        data_t   v1;
        tag_t    q1;
        logic    r1;      // v1 holds a valid value
        data_t   v2;
        tag_t    q2;
        logic    r2;      // v2 holds a valid value
        data_t   imm;
        addr_t   pc;
        tag_t    dest;
    } rs_entry_t;

endpackage

/* rtl/issue_if.sv */
`timescale 1ns/100ps

interface issue_if import rv_isa_pkg::*, rs_pkg::*; ();

    logic    valid;   // One cycle per issued instruction
    openum_t openum;
    data_t   v1;
    data_t   v2;
    data_t   imm;
    addr_t   pc;
    tag_t    dest;

    modport src (
        output valid,
        output openum,
        output v1,
        output v2,
        output imm,
        output pc,
        output dest
    );

    modport dst (
        input valid,
        input openum,
        input v1,
        input v2,
        input imm,
        input pc,
        input dest
    );

endinterface

/* rtl/cdb_if.sv */
`timescale 1ns/100ps

interface cdb_if import rv_isa_pkg::*, rs_pkg::*; ();

    logic  valid;
    tag_t  tag;         // Producer tag, seen once per instruction
    data_t result;
    addr_t target_pc;
    logic  jump_flag;

    modport src (
        output valid,
        output tag,
        output result,
        output target_pc,
        output jump_flag
    );

    modport snoop (
        input valid,
        input tag,
        input result,
        input target_pc,
        input jump_flag
    );

endinterface

/* rtl/rs_station.sv */
`timescale 1ns/100ps

module rs_station import rv_isa_pkg::*, rs_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    dispatch_valid,
    input  openum_t dispatch_openum,
    input  data_t   dispatch_v1,
    input  tag_t    dispatch_q1,
    input  logic    dispatch_r1,
    input  data_t   dispatch_v2,
    input  tag_t    dispatch_q2,
    input  logic    dispatch_r2,
    input  data_t   dispatch_imm,
    input  addr_t   dispatch_pc,
    input  tag_t    dispatch_dest,
    output logic    full,
    issue_if.src    issue,
    cdb_if.snoop    cdb
);

    rs_entry_t           entry_q [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy_vec;
    logic [RS_DEPTH-1:0] ready_vec;
    rs_idx_t             free_idx;
    rs_idx_t             issue_idx;
    logic                issue_found;
    data_t               d_v1;
    data_t               d_v2;
    logic                d_r1;
    logic                d_r2;

    // Priority pick, lowest index wins
    function automatic rs_idx_t lowest_set(input logic [RS_DEPTH-1:0] vec);
        rs_idx_t idx;
        idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = rs_idx_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            busy_vec[i]  = entry_q[i].busy;
            ready_vec[i] = entry_q[i].busy && entry_q[i].r1 && entry_q[i].r2;
        end
    end

    assign full        = &busy_vec;
    assign free_idx    = lowest_set(~busy_vec);
    assign issue_found = |ready_vec;
    assign issue_idx   = lowest_set(ready_vec);

    // Catch a producer that broadcasts in the dispatch cycle
    always_comb begin
        d_v1 = dispatch_v1;
        d_r1 = dispatch_r1;
        d_v2 = dispatch_v2;
        d_r2 = dispatch_r2;
        if (!dispatch_r1 && cdb.valid && (cdb.tag == dispatch_q1)) begin
            d_v1 = cdb.result;
            d_r1 = 1'b1;
        end
        if (!dispatch_r2 && cdb.valid && (cdb.tag == dispatch_q2)) begin
            d_v2 = cdb.result;
            d_r2 = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                entry_q[i].busy <= 1'b0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (cdb.valid && entry_q[i].busy) begin  // Wakeup from CDB
                    if (!entry_q[i].r1 && (entry_q[i].q1 == cdb.tag)) begin
                        entry_q[i].v1 <= cdb.result;
                        entry_q[i].r1 <= 1'b1;
                    end
                    if (!entry_q[i].r2 && (entry_q[i].q2 == cdb.tag)) begin
                        entry_q[i].v2 <= cdb.result;
                        entry_q[i].r2 <= 1'b1;
                    end
                end
            end
            if (issue_found) begin
                entry_q[issue_idx].busy <= 1'b0;
            end
            if (dispatch_valid && !full) begin
                entry_q[free_idx] <= '{
                    busy:   1'b1,
                    openum: dispatch_openum,
                    v1:     d_v1,
                    q1:     dispatch_q1,
                    r1:     d_r1,
                    v2:     d_v2,
                    q2:     dispatch_q2,
                    r2:     d_r2,
                    imm:    dispatch_imm,
                    pc:     dispatch_pc,
                    dest:   dispatch_dest
                };
            end
        end
    end

    assign issue.valid  = issue_found;
    assign issue.openum = entry_q[issue_idx].openum;
    assign issue.v1     = entry_q[issue_idx].v1;
    assign issue.v2     = entry_q[issue_idx].v2;
    assign issue.imm    = entry_q[issue_idx].imm;
    assign issue.pc     = entry_q[issue_idx].pc;
    assign issue.dest   = entry_q[issue_idx].dest;

    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (reset) dispatch_valid |-> !full
    ) else $error("rs_station: dispatch while full");

    a_issue_not_nop: assert property (
        @(posedge clk) disable iff (reset) issue.valid |-> (issue.openum != OPENUM_NOP)
    ) else $error("rs_station: NOP issued, openum=%h", issue.openum);

endmodule

/* rtl/rs_ex.sv */
`timescale 1ns/100ps

module rs_ex import rv_isa_pkg::*, rs_pkg::*; (
    input  logic clk,
    input  logic reset,
    issue_if.dst issue,
    cdb_if.src   cdb
);

    data_t      result;
    addr_t      target_pc;
    logic       jump_flag;
    logic [4:0] shamt_r;
    logic [4:0] shamt_i;

    logic       valid_q;
    logic       jump_flag_q;
    tag_t       tag_q;
    data_t      result_q;
    addr_t      target_pc_q;

    assign shamt_r = issue.v2[4:0];
    assign shamt_i = issue.imm[4:0];

    always_comb begin
        result    = ZERO_WORD;
        target_pc = ZERO_ADDR;
        jump_flag = 1'b0;
        case (issue.valid ? issue.openum : OPENUM_NOP)  // Idle cycles decode as NOP
            OPENUM_LUI:   result = issue.imm;
            OPENUM_AUIPC: result = issue.pc + issue.imm;
            OPENUM_JAL: begin
                target_pc = issue.pc + issue.imm;
                result    = issue.pc + PC_STEP;
                jump_flag = 1'b1;
            end
            OPENUM_JALR: begin
                target_pc = issue.v1 + issue.imm;
                result    = issue.pc + PC_STEP;
                jump_flag = 1'b1;
            end
            OPENUM_BEQ:   jump_flag = (issue.v1 == issue.v2);
            OPENUM_BNE:   jump_flag = (issue.v1 != issue.v2);
            OPENUM_BLT:   jump_flag = ($signed(issue.v1) < $signed(issue.v2));
            OPENUM_BGE:   jump_flag = ($signed(issue.v1) >= $signed(issue.v2));
            OPENUM_BLTU:  jump_flag = (issue.v1 < issue.v2);
            OPENUM_BGEU:  jump_flag = (issue.v1 >= issue.v2);
            OPENUM_ADD:   result = issue.v1 + issue.v2;
            OPENUM_SUB:   result = issue.v1 - issue.v2;
            OPENUM_SLL:   result = issue.v1 << shamt_r;
            OPENUM_SLT:   result = data_t'($signed(issue.v1) < $signed(issue.v2));
            OPENUM_SLTU:  result = data_t'(issue.v1 < issue.v2);
            OPENUM_XOR:   result = issue.v1 ^ issue.v2;
            OPENUM_SRL:   result = issue.v1 >> shamt_r;
            OPENUM_SRA:   result = data_t'($signed(issue.v1) >>> shamt_r);
            OPENUM_OR:    result = issue.v1 | issue.v2;
            OPENUM_AND:   result = issue.v1 & issue.v2;
            OPENUM_ADDI:  result = issue.v1 + issue.imm;
            OPENUM_SLLI:  result = issue.v1 << shamt_i;
            OPENUM_SLTI:  result = data_t'($signed(issue.v1) < $signed(issue.imm));
            OPENUM_SLTIU: result = data_t'(issue.v1 < issue.imm);
            OPENUM_XORI:  result = issue.v1 ^ issue.imm;
            OPENUM_SRLI:  result = issue.v1 >> shamt_i;
            OPENUM_SRAI:  result = data_t'($signed(issue.v1) >>> shamt_i);
            OPENUM_ORI:   result = issue.v1 | issue.imm;
            OPENUM_ANDI:  result = issue.v1 & issue.imm;
            default: ;
        endcase

        // Branches report the taken condition in result as well
        if (issue.openum inside {[OPENUM_BEQ:OPENUM_BGEU]}) begin
            target_pc = issue.pc + issue.imm;
            result    = data_t'(jump_flag);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= 1'b0;
            jump_flag_q <= 1'b0;
        end else begin
            valid_q     <= issue.valid;
            jump_flag_q <= jump_flag;
        end
    end

    always_ff @(posedge clk) begin
        tag_q       <= issue.dest;
        result_q    <= result;
        target_pc_q <= target_pc;
    end

    assign cdb.valid     = valid_q;
    assign cdb.tag       = tag_q;
    assign cdb.result    = result_q;
    assign cdb.target_pc = target_pc_q;
    assign cdb.jump_flag = jump_flag_q;

    a_jump_needs_valid: assert property (
        @(posedge clk) disable iff (reset) cdb.jump_flag |-> cdb.valid
    ) else $error("rs_ex: jump_flag without CDB valid");

endmodule

/* rtl/rs_alu_top.sv */
`timescale 1ns/100ps

module rs_alu_top import rv_isa_pkg::*, rs_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    dispatch_valid,
    input  openum_t dispatch_openum,
    input  data_t   dispatch_v1,
    input  tag_t    dispatch_q1,
    input  logic    dispatch_r1,
    input  data_t   dispatch_v2,
    input  tag_t    dispatch_q2,
    input  logic    dispatch_r2,
    input  data_t   dispatch_imm,
    input  addr_t   dispatch_pc,
    input  tag_t    dispatch_dest,
    output logic    full,
    output logic    cdb_valid,
    output tag_t    cdb_tag,
    output data_t   cdb_result,
    output addr_t   cdb_target_pc,
    output logic    cdb_jump_flag
);

    issue_if issue_bus ();
    cdb_if   cdb_bus ();

    rs_station rs_station_i (
        .clk             (clk),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_openum (dispatch_openum),
        .dispatch_v1     (dispatch_v1),
        .dispatch_q1     (dispatch_q1),
        .dispatch_r1     (dispatch_r1),
        .dispatch_v2     (dispatch_v2),
        .dispatch_q2     (dispatch_q2),
        .dispatch_r2     (dispatch_r2),
        .dispatch_imm    (dispatch_imm),
        .dispatch_pc     (dispatch_pc),
        .dispatch_dest   (dispatch_dest),
        .full            (full),
        .issue           (issue_bus.src),
        .cdb             (cdb_bus.snoop)
    );

    rs_ex rs_ex_i (
        .clk   (clk),
        .reset (reset),
        .issue (issue_bus.dst),
        .cdb   (cdb_bus.src)
    );

    // CDB also leaves the block for the reorder buffer
    assign cdb_valid     = cdb_bus.valid;
    assign cdb_tag       = cdb_bus.tag;
    assign cdb_result    = cdb_bus.result;
    assign cdb_target_pc = cdb_bus.target_pc;
    assign cdb_jump_flag = cdb_bus.jump_flag;

endmodule

/* tb/rs_alu_tb.sv */
`timescale 1ns/100ps

module rs_alu_tb import rv_isa_pkg::*, rs_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int N_OPS      = int'(OPENUM_ANDI);  // Every operation except NOP
    localparam int SWEEP_REPS = 3;
    localparam int N_RANDOM   = 200;
    localparam int N_TESTS    = SWEEP_REPS * N_OPS + N_RANDOM + 9 + RS_DEPTH + 4;
    localparam int N_TAGS     = 2 ** TAG_W;
    localparam int DEP_NONE   = -1;
    localparam int DEP_ANY    = -2;

    logic    clk;
    logic    reset;
    logic    dispatch_valid;
    openum_t dispatch_openum;
    data_t   dispatch_v1, dispatch_v2, dispatch_imm;
    tag_t    dispatch_q1, dispatch_q2, dispatch_dest;
    logic    dispatch_r1, dispatch_r2;
    addr_t   dispatch_pc;
    logic    full;
    logic    cdb_valid;
    tag_t    cdb_tag;
    data_t   cdb_result;
    addr_t   cdb_target_pc;
    logic    cdb_jump_flag;

    logic [31:0]       seed;
    logic [N_TAGS-1:0] in_flight;
    data_t             exp_result [N_TAGS];
    addr_t             exp_target [N_TAGS];
    logic              exp_flag   [N_TAGS];
    tag_t              free_tags [$];
    tag_t              tag_hold;
    tag_t              withheld;
    data_t             withheld_v1;

    rs_alu_top rs_alu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Biased toward sign boundaries and small shift amounts
    function automatic data_t pick_value();
        logic [31:0] r;
        r = next_random();
        case (r[2:0])
            3'd0: return 32'h8000_0000;
            3'd1: return 32'hffff_ffff;
            3'd2: return data_t'(r[7:3]);
            3'd3: return -data_t'(r[10:3]);
            default: return next_random();
        endcase
    endfunction

    // RV32I rules, branches also report the condition in result
    function automatic void expected_outcome(input openum_t op, input data_t a, input data_t b,
                                             input data_t imm, input addr_t pc,
                                             output data_t res, output addr_t tgt,
                                             output logic jmp);
        data_t s2;
        logic  cond;
        s2   = (op >= OPENUM_ADDI) ? imm : b;
        res  = '0;
        tgt  = '0;
        jmp  = 1'b0;
        cond = 1'b0;
        case (op)
            OPENUM_LUI:                res = imm;
            OPENUM_AUIPC:              res = pc + imm;
            OPENUM_JAL, OPENUM_JALR: begin
                res = pc + 32'd4;
                jmp = 1'b1;
                tgt = (op == OPENUM_JAL) ? pc + imm : a + imm;
            end
            OPENUM_BEQ:                cond = (a == b);
            OPENUM_BNE:                cond = (a != b);
            OPENUM_BLT:                cond = ($signed(a) < $signed(b));
            OPENUM_BGE:                cond = !($signed(a) < $signed(b));
            OPENUM_BLTU:               cond = (a < b);
            OPENUM_BGEU:               cond = !(a < b);
            OPENUM_ADD, OPENUM_ADDI:   res = a + s2;
            OPENUM_SUB:                res = a - b;
            OPENUM_SLL, OPENUM_SLLI:   res = a << s2[4:0];
            OPENUM_SLT, OPENUM_SLTI:   res = {31'b0, $signed(a) < $signed(s2)};
            OPENUM_SLTU, OPENUM_SLTIU: res = {31'b0, a < s2};
            OPENUM_XOR, OPENUM_XORI:   res = a ^ s2;
            OPENUM_SRL, OPENUM_SRLI:   res = a >> s2[4:0];
            OPENUM_SRA, OPENUM_SRAI:   res = $unsigned($signed(a) >>> s2[4:0]);
            OPENUM_OR, OPENUM_ORI:     res = a | s2;
            OPENUM_AND, OPENUM_ANDI:   res = a & s2;
            default: ;
        endcase
        if (op >= OPENUM_BEQ && op <= OPENUM_BGEU) begin
            jmp = cond;
            res = {31'b0, cond};
            tgt = pc + imm;
        end
    endfunction

    task automatic expect_tag(input tag_t dest, input openum_t op, input data_t a,
                              input data_t b, input data_t imm, input addr_t pc);
        expected_outcome(op, a, b, imm, pc, exp_result[dest], exp_target[dest], exp_flag[dest]);
        in_flight[dest] = 1'b1;
    endtask

    // An operand either names an in-flight producer or carries its value
    function automatic void pick_operand(input int dep, output data_t drv, output tag_t q,
                                         output logic rdy, output data_t val);
        tag_t t;
        t   = tag_t'(next_random());
        drv = pick_value();
        q   = '0;
        rdy = 1'b1;
        val = drv;
        if (dep == DEP_ANY && in_flight != '0 && next_random() % 2 == 1) begin
            while (!in_flight[t]) begin
                t = t + 1'b1;
            end
            q   = t;
            rdy = 1'b0;
            val = exp_result[t];
        end else if (dep >= 0) begin
            if (in_flight[dep]) begin
                q   = tag_t'(dep);
                rdy = 1'b0;
                val = exp_result[dep];
            end else begin
                drv = exp_result[dep];  // Producer already done
                val = drv;
            end
        end
    endfunction

    task automatic wait_slot();
        @(negedge clk);
        while (full || free_tags.size() == 0) begin
            dispatch_valid = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic drive_dispatch(input openum_t op, input data_t v1, input tag_t q1,
                                  input logic r1, input data_t v2, input tag_t q2,
                                  input logic r2, input data_t imm, input addr_t pc,
                                  input tag_t dest);
        dispatch_valid  = 1'b1;
        dispatch_openum = op;
        dispatch_v1     = v1;
        dispatch_q1     = q1;
        dispatch_r1     = r1;
        dispatch_v2     = v2;
        dispatch_q2     = q2;
        dispatch_r2     = r2;
        dispatch_imm    = imm;
        dispatch_pc     = pc;
        dispatch_dest   = dest;
    endtask

    task automatic send(input openum_t op, input int dep1, input int dep2, output tag_t dest);
        data_t       v1, v2, a, b, imm;
        tag_t        q1, q2;
        logic        r1, r2;
        logic [31:0] r;
        addr_t       pc;
        wait_slot();
        pick_operand(dep1, v1, q1, r1, a);
        pick_operand(dep2, v2, q2, r2, b);
        if (op >= OPENUM_BEQ && op <= OPENUM_BGEU && r1 && r2 && next_random() % 2 == 1) begin
            v2 = v1;  // Equal pair flips the outcome of each branch
            b  = a;
        end
        r    = next_random();
        imm  = (op inside {OPENUM_LUI, OPENUM_AUIPC}) ? {r[31:12], 12'h0} : {{20{r[11]}}, r[11:0]};
        pc   = next_random() & 32'hffff_fffc;
        dest = free_tags.pop_front();
        expect_tag(dest, op, a, b, imm, pc);
        drive_dispatch(op, v1, q1, r1, v2, q2, r2, imm, pc, dest);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            dispatch_valid = 1'b0;
        end
    endtask

    task automatic drain();
        do begin
            @(negedge clk);
            dispatch_valid = 1'b0;
        end while (in_flight != '0);
    endtask

    // Scoreboard keyed by tag, values are settled before the edge
    always @(posedge clk) begin
        if (!reset && cdb_valid) begin
            assert (in_flight[cdb_tag])
                else stop_with_failure($sformatf("unknown tag %h broadcast on the CDB", cdb_tag));
            assert (cdb_result == exp_result[cdb_tag])
                else stop_with_failure($sformatf("error cdb_result tag %h: got %h, expected %h",
                                                 cdb_tag, cdb_result, exp_result[cdb_tag]));
            assert (cdb_target_pc == exp_target[cdb_tag])
                else stop_with_failure($sformatf("error cdb_target_pc tag %h: got %h, expected %h",
                                                 cdb_tag, cdb_target_pc, exp_target[cdb_tag]));
            assert (cdb_jump_flag == exp_flag[cdb_tag])
                else stop_with_failure($sformatf("error cdb_jump_flag tag %h: got %h, expected %h",
                                                 cdb_tag, cdb_jump_flag, exp_flag[cdb_tag]));
            in_flight[cdb_tag] = 1'b0;
            free_tags.push_back(cdb_tag);
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(reset) |-> !cdb_valid && !full)
        else stop_with_failure("cdb_valid or full is high right after reset");

    a_flag_with_valid: assert property (
        @(posedge clk) disable iff (reset) cdb_jump_flag |-> cdb_valid
    ) else stop_with_failure($sformatf("error cdb_jump_flag: got %h while cdb_valid is %h",
                                       cdb_jump_flag, cdb_valid));

    initial begin
        #((N_TESTS * 20 + 4) * CLK_PERIOD);
        stop_with_failure("watchdog expired before all tags came back on the CDB");
    end

    initial begin
        seed            = 32'he28d;
        reset           = 1'b1;
        in_flight       = '0;
        withheld_v1     = '0;
        drive_dispatch(OPENUM_NOP, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0, '0);
        dispatch_valid  = 1'b0;
        for (int t = 0; t < N_TAGS; t++) begin
            free_tags.push_back(tag_t'(t));
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        for (int rep = 0; rep < SWEEP_REPS; rep++) begin
            for (int k = 1; k <= N_OPS; k++) begin
                send(openum_t'(k), DEP_NONE, DEP_NONE, tag_hold);
            end
        end
        drain();

        for (int i = 0; i < N_RANDOM; i++) begin
            send(openum_t'(1 + next_random() % N_OPS), DEP_ANY, DEP_ANY, tag_hold);
            if (next_random() % 4 == 0) begin
                idle_cycles(1);
            end
        end
        drain();

        // Gap 1 puts the consumer's dispatch on the producer's broadcast cycle
        for (int gap = 0; gap < 3; gap++) begin
            send(OPENUM_ADDI, DEP_NONE, DEP_NONE, withheld);
            idle_cycles(gap);
            send(OPENUM_ADD, withheld, DEP_NONE, tag_hold);
            send(OPENUM_SRA, tag_hold, withheld, tag_hold);
            drain();
        end

        // Fill the station behind a producer that is dispatched last
        withheld    = free_tags.pop_front();
        withheld_v1 = pick_value();
        expect_tag(withheld, OPENUM_ADDI, withheld_v1, '0, 32'h0000_0123, 32'h0000_1000);
        for (int i = 0; i < RS_DEPTH - 1; i++) begin
            send(OPENUM_ADD, withheld, DEP_NONE, tag_hold);
        end
        wait_slot();
        drive_dispatch(OPENUM_ADDI, withheld_v1, '0, 1'b1, '0, '0, 1'b1, 32'h0000_0123,
                       32'h0000_1000, withheld);
        idle_cycles(1);
        assert (full) else stop_with_failure("full did not rise with every entry busy");
        for (int i = 0; i < 4; i++) begin
            send(openum_t'(1 + next_random() % N_OPS), DEP_ANY, DEP_ANY, tag_hold);
        end
        drain();
        idle_cycles(2);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* rs_alu.f */
rtl/rv_isa_pkg.sv
rtl/rs_pkg.sv
rtl/issue_if.sv
rtl/cdb_if.sv
rtl/rs_station.sv
rtl/rs_ex.sv
rtl/rs_alu_top.sv
tb/rs_alu_tb.sv

/* Bender.yml */
package:
  name: rs_alu

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/rs_pkg.sv
  - rtl/issue_if.sv
  - rtl/cdb_if.sv
  - rtl/rs_station.sv
  - rtl/rs_ex.sv
  - rtl/rs_alu_top.sv
  - target: test
    files:
      - tb/rs_alu_tb.sv
